//--- vlog.f
mul_pkg.sv
flux_sched_fsm.sv
block_counter.sv
coeff_mul_datapath.sv
mul_18_top.sv
tb_clock_gen.sv
tb_mul_18.sv

//--- tb_mul_18.sv
// FLUX fixed to 4; inputs change on the rising edge, outputs are sampled on the falling edge
`default_nettype none

module tb_mul_18;

    localparam int          flux     = 4;
    localparam int          n_blocks = 5;
    localparam int          max_ops  = 256;
    localparam int          period   = 40;
    localparam logic [31:0] seed     = 32'hf1a3d3da;

    // test indices
    localparam int t_reset = 0;
    localparam int t_prod  = 1;
    localparam int t_block = 2;
    localparam int t_prio  = 3;
    localparam int t_bp    = 4;
    localparam int t_done  = 5;

    logic                                clk;
    logic                                rst;
    logic [flux-1:0]                     coeff_empty;
    logic [flux-1:0]                     ext_empty;
    logic [flux-1:0]                     real_empty;
    logic [flux-1:0]                     opa_empty;
    logic [flux-1:0]                     prod_full;
    logic [mul_pkg::coeff_width-1:0]     coeff_data [flux];
    logic [mul_pkg::size_width-1:0]      ext_data [flux];
    logic [mul_pkg::size_width-1:0]      real_data [flux];
    logic [mul_pkg::op_a_width-1:0]      opa_data [flux];
    logic [flux-1:0]                     coeff_read;
    logic [flux-1:0]                     ext_read;
    logic [flux-1:0]                     real_read;
    logic [flux-1:0]                     opa_read;
    logic                                prod_write;
    logic [$clog2(flux)-1:0]             prod_tag;
    logic [mul_pkg::prod_width-1:0]      prod_data;

    // source queues and expected products indexed by channel
    logic signed [mul_pkg::coeff_width-1:0] coeff_src [flux][n_blocks];
    logic [mul_pkg::size_width-1:0]         ext_src [flux][n_blocks];
    logic [mul_pkg::size_width-1:0]         real_src [flux][n_blocks];
    logic signed [mul_pkg::op_a_width-1:0]  opa_src [flux][max_ops];
    logic signed [mul_pkg::prod_width-1:0]  exp_prod [flux][max_ops];

    int          n_ops [flux];
    int          cfg_head [flux];
    int          opa_head [flux];
    int          exp_idx [flux];
    // operands left in the current block where zero means IDLE
    int          left [flux];
    int          chk [6];
    int          err [6];
    int          cycles;
    int          limit;
    logic        started;
    logic [31:0] lfsr;

    tb_clock_gen #(
        .period (period)
    ) i_clock (
        .clk (clk)
    );

    mul_18_top #(
        .FLUX (flux)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .coeff_empty (coeff_empty),
        .coeff_data  (coeff_data),
        .coeff_read  (coeff_read),
        .ext_empty   (ext_empty),
        .ext_data    (ext_data),
        .ext_read    (ext_read),
        .real_empty  (real_empty),
        .real_data   (real_data),
        .real_read   (real_read),
        .opa_empty   (opa_empty),
        .opa_data    (opa_data),
        .opa_read    (opa_read),
        .prod_full   (prod_full),
        .prod_write  (prod_write),
        .prod_tag    (prod_tag),
        .prod_data   (prod_data)
    );

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            t_reset: return "reset";
            t_prod:  return "products";
            t_block: return "block length";
            t_prio:  return "priority";
            t_bp:    return "back-pressure";
            default: return "completion";
        endcase
    endfunction

    task automatic value_error(input int t, input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        err[t]++;
        $display("ERROR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic fault(input int t, input string msg);
        err[t]++;
        $display("t=%0t %s", $time, msg);
    endtask

    task automatic print_test(input int t);
        $display("test %s: %0d checks, %0d errors", test_name(t), chk[t], err[t]);
    endtask

    // blocks of random size where each product uses the coefficient of its block
    task automatic build_stimulus();
        int k;
        int n;
        int total_items;
        total_items = 0;
        for (int c = 0; c < flux; c++)
        begin
            k = 0;
            for (int b = 0; b < n_blocks; b++)
            begin
                ext_src[c][b]   = take_bits(3) % 7 + 1;
                real_src[c][b]  = take_bits(3) % 7 + 1;
                coeff_src[c][b] = take_bits(mul_pkg::coeff_width);
                n = int'(ext_src[c][b]) * int'(real_src[c][b]);
                for (int j = 0; j < n; j++)
                begin
                    opa_src[c][k]  = take_bits(mul_pkg::op_a_width);
                    exp_prod[c][k] = opa_src[c][k] * coeff_src[c][b];
                    k++;
                end
            end
            n_ops[c] = k;
            total_items += k + n_blocks;
        end
        limit = total_items * 8 + 200;
    endtask

    function automatic logic finished();
        logic f;
        f = 1'b1;
        for (int c = 0; c < flux; c++)
        begin
            if (cfg_head[c] < n_blocks || opa_head[c] < n_ops[c] || exp_idx[c] < n_ops[c])
                f = 1'b0;
        end
        return f;
    endfunction

    // source and sink flags and the data at the head of each queue
    always @(posedge clk)
    begin
        if (started)
        begin
            cycles++;
            if (cycles > limit)
            begin
                $display("timeout after %0d cycles, queued items were not all consumed", cycles);
                $display("Test failures found");
                $finish;
            end
            else
            begin
                for (int c = 0; c < flux; c++)
                begin
                    coeff_empty[c] <= (take_bits(2) == 0) || (cfg_head[c] >= n_blocks);
                    ext_empty[c]   <= (take_bits(2) == 0) || (cfg_head[c] >= n_blocks);
                    real_empty[c]  <= (take_bits(2) == 0) || (cfg_head[c] >= n_blocks);
                    opa_empty[c]   <= (take_bits(2) == 0) || (opa_head[c] >= n_ops[c]);
                    prod_full[c]   <= (take_bits(2) == 0);
                    if (cfg_head[c] < n_blocks)
                    begin
                        coeff_data[c] <= coeff_src[c][cfg_head[c]];
                        ext_data[c]   <= ext_src[c][cfg_head[c]];
                        real_data[c]  <= real_src[c][cfg_head[c]];
                    end
                    if (opa_head[c] < n_ops[c])
                        opa_data[c] <= opa_src[c][opa_head[c]];
                end
            end
        end
    end

    // checks against the model before the pops follow the strobes
    always @(negedge clk)
    begin : check_cycle
        int   exp_ch;
        int   tag;
        logic rdy;
        logic exp_cfg;
        logic exp_opa;
        logic exp_wr;
        if (started)
        begin
            exp_ch = -1;
            for (int c = flux - 1; c >= 0; c--)
            begin
                if (left[c] == 0)
                    rdy = !coeff_empty[c] && !ext_empty[c] && !real_empty[c];
                else
                    rdy = !opa_empty[c] && !prod_full[c];
                if (rdy)
                    exp_ch = c;
            end
            exp_wr = 1'b0;
            for (int c = 0; c < flux; c++)
            begin
                exp_cfg = (exp_ch == c) && (left[c] == 0);
                exp_opa = (exp_ch == c) && (left[c] != 0);
                chk[t_prio] += 4;
                if (coeff_read[c] !== exp_cfg)
                    value_error(t_prio, $sformatf("coeff_read[%0d]", c), coeff_read[c], exp_cfg);
                if (ext_read[c] !== exp_cfg)
                    value_error(t_prio, $sformatf("ext_read[%0d]", c), ext_read[c], exp_cfg);
                if (real_read[c] !== exp_cfg)
                    value_error(t_prio, $sformatf("real_read[%0d]", c), real_read[c], exp_cfg);
                if (opa_read[c] !== exp_opa)
                    value_error(t_prio, $sformatf("opa_read[%0d]", c), opa_read[c], exp_opa);
                chk[t_block] += 2;
                if (coeff_read[c] === 1'b1 && left[c] != 0)
                    fault(t_block, $sformatf("channel %0d read a config with %0d operands left",
                                             c, left[c]));
                if (opa_read[c] === 1'b1 && left[c] == 0)
                    fault(t_block, $sformatf("channel %0d read an operand outside a block", c));
                chk[t_bp]++;
                if (opa_read[c] === 1'b1 && prod_full[c])
                    fault(t_bp, $sformatf("channel %0d popped an operand while its sink was full",
                                          c));
                if (exp_opa)
                    exp_wr = 1'b1;
            end
            chk[t_prod]++;
            if (prod_write !== exp_wr)
                value_error(t_prod, "prod_write", prod_write, exp_wr);
            if (prod_write === 1'b1)
            begin
                tag = prod_tag;
                chk[t_prod]++;
                chk[t_bp]++;
                if (tag != exp_ch)
                    value_error(t_prod, "prod_tag", prod_tag, exp_ch);
                if (prod_full[tag])
                    fault(t_bp, $sformatf("product written to channel %0d while it was full", tag));
                if (exp_idx[tag] >= n_ops[tag])
                begin
                    fault(t_prod, $sformatf("channel %0d wrote more products than operands", tag));
                end
                else
                begin
                    chk[t_prod]++;
                    if (prod_data !== exp_prod[tag][exp_idx[tag]])
                        value_error(t_prod, $sformatf("prod_data[ch %0d]", tag), prod_data,
                                    $unsigned(exp_prod[tag][exp_idx[tag]]));
                    exp_idx[tag]++;
                end
            end
            // model update from the strobes the DUT gave
            for (int c = 0; c < flux; c++)
            begin
                if (coeff_read[c] === 1'b1 && cfg_head[c] < n_blocks)
                begin
                    left[c] = int'(ext_src[c][cfg_head[c]]) * int'(real_src[c][cfg_head[c]]);
                    cfg_head[c]++;
                end
                if (opa_read[c] === 1'b1 && opa_head[c] < n_ops[c])
                begin
                    opa_head[c]++;
                    if (left[c] != 0)
                        left[c]--;
                end
            end
        end
    end

    initial
    begin : main
        int total_chk;
        int total_err;
        lfsr        = seed;
        rst         = 1'b1;
        started     = 1'b0;
        cycles      = 0;
        coeff_empty = '1;
        ext_empty   = '1;
        real_empty  = '1;
        opa_empty   = '1;
        prod_full   = '0;
        for (int c = 0; c < flux; c++)
        begin
            coeff_data[c] = '0;
            ext_data[c]   = '0;
            real_data[c]  = '0;
            opa_data[c]   = '0;
            cfg_head[c]   = 0;
            opa_head[c]   = 0;
            exp_idx[c]    = 0;
            left[c]       = 0;
        end
        for (int t = 0; t < 6; t++)
        begin
            chk[t] = 0;
            err[t] = 0;
        end
        build_stimulus();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        // all sources still empty in the first cycle out of reset
        @(negedge clk);
        chk[t_reset] += 2;
        if ({coeff_read, ext_read, real_read, opa_read} !== '0)
            value_error(t_reset, "coeff_read/ext_read/real_read/opa_read",
                        {coeff_read, ext_read, real_read, opa_read}, 0);
        if (prod_write !== 1'b0)
            value_error(t_reset, "prod_write", prod_write, 0);
        print_test(t_reset);
        @(posedge clk);
        started <= 1'b1;

        while (!finished())
            @(posedge clk);

        for (int c = 0; c < flux; c++)
        begin
            chk[t_done]++;
            if (left[c] != 0 || exp_idx[c] != n_ops[c])
                fault(t_done, $sformatf("channel %0d ended with an unfinished block", c));
        end
        total_chk = 0;
        total_err = 0;
        for (int t = 1; t < 6; t++)
            print_test(t);
        for (int t = 0; t < 6; t++)
        begin
            total_chk += chk[t];
            total_err += err[t];
        end
        $display("total: %0d checks, %0d errors in %0d cycles", total_chk, total_err, cycles);
        if (total_err == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// free-running testbench clock with no enable; starts low and rises at half a period
`default_nettype none

module tb_clock_gen #(
    parameter int period = 40
) (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- mul_18_top.sv
// FLUX must be at least 2; FIFOs are show-ahead, a read strobe pops at the next edge
`default_nettype none

module mul_18_top #(
    parameter int FLUX = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,

    // config sources
    input  wire logic [FLUX-1:0]                      coeff_empty,
    input  wire logic [mul_pkg::coeff_width-1:0]      coeff_data [FLUX],
    output logic [FLUX-1:0]                           coeff_read,
    input  wire logic [FLUX-1:0]                      ext_empty,
    input  wire logic [mul_pkg::size_width-1:0]       ext_data [FLUX],
    output logic [FLUX-1:0]                           ext_read,
    input  wire logic [FLUX-1:0]                      real_empty,
    input  wire logic [mul_pkg::size_width-1:0]       real_data [FLUX],
    output logic [FLUX-1:0]                           real_read,

    // operand source
    input  wire logic [FLUX-1:0]                      opa_empty,
    input  wire logic [mul_pkg::op_a_width-1:0]       opa_data [FLUX],
    output logic [FLUX-1:0]                           opa_read,

    // product sink
    input  wire logic [FLUX-1:0]                      prod_full,
    output logic                                      prod_write,
    output logic [$clog2(FLUX)-1:0]                   prod_tag,
    output logic [mul_pkg::prod_width-1:0]            prod_data
);

    logic [$clog2(FLUX)-1:0] sel_tag;
    logic                    load;
    logic                    step;
    logic                    last;

    flux_sched_fsm #(
        .FLUX (FLUX)
    ) i_sched (
        .clk         (clk),
        .rst         (rst),
        .coeff_empty (coeff_empty),
        .ext_empty   (ext_empty),
        .real_empty  (real_empty),
        .opa_empty   (opa_empty),
        .prod_full   (prod_full),
        .last        (last),
        .sel_tag     (sel_tag),
        .load        (load),
        .step        (step),
        .coeff_read  (coeff_read),
        .ext_read    (ext_read),
        .real_read   (real_read),
        .opa_read    (opa_read)
    );

    block_counter #(
        .FLUX (FLUX)
    ) i_counter (
        .clk       (clk),
        .rst       (rst),
        .sel_tag   (sel_tag),
        .load      (load),
        .step      (step),
        .ext_data  (ext_data),
        .real_data (real_data),
        .last      (last)
    );

    coeff_mul_datapath #(
        .FLUX (FLUX)
    ) i_datapath (
        .clk        (clk),
        .rst        (rst),
        .sel_tag    (sel_tag),
        .load       (load),
        .step       (step),
        .coeff_data (coeff_data),
        .opa_data   (opa_data),
        .prod_write (prod_write),
        .prod_tag   (prod_tag),
        .prod_data  (prod_data)
    );

endmodule

`default_nettype wire

//--- coeff_mul_datapath.sv
// zero-latency product; outputs are zero whenever step is low
`default_nettype none

module coeff_mul_datapath #(
    parameter int FLUX = 2
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire logic [$clog2(FLUX)-1:0]              sel_tag,
    input  wire logic                                 load,
    input  wire logic                                 step,
    input  wire logic [mul_pkg::coeff_width-1:0]      coeff_data [FLUX],
    input  wire logic [mul_pkg::op_a_width-1:0]       opa_data [FLUX],
    output logic                                      prod_write,
    output logic [$clog2(FLUX)-1:0]                   prod_tag,
    output logic [mul_pkg::prod_width-1:0]            prod_data
);

    // one stored coefficient per channel
    logic signed [mul_pkg::coeff_width-1:0] coeff_mem [FLUX];

    logic signed [mul_pkg::coeff_width-1:0] coeff_sel;
    logic signed [mul_pkg::op_a_width-1:0]  opa_sel;
    logic signed [mul_pkg::prod_width-1:0]  product;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FLUX; i++)
            begin
                coeff_mem[i] <= '0;
            end
        end
        else if (load)
        begin
            coeff_mem[sel_tag] <= coeff_data[sel_tag];
        end
    end

    assign coeff_sel = coeff_mem[sel_tag];
    assign opa_sel   = opa_data[sel_tag];

    // both operands signed, so the result is sign-extended to 27 bits
    assign product = opa_sel * coeff_sel;

    always_comb
    begin
        if (step)
        begin
            prod_write = 1'b1;
            prod_tag   = sel_tag;
            prod_data  = product;
        end
        else
        begin
            prod_write = 1'b0;
            prod_tag   = '0;
            prod_data  = '0;
        end
    end

endmodule

`default_nettype wire

//--- block_counter.sv
// sizes of zero are not supported; last is only meaningful while step is high
`default_nettype none

module block_counter #(
    parameter int FLUX = 2
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [$clog2(FLUX)-1:0]       sel_tag,
    input  wire logic                          load,
    input  wire logic                          step,
    input  wire logic [mul_pkg::size_width-1:0] ext_data [FLUX],
    input  wire logic [mul_pkg::size_width-1:0] real_data [FLUX],
    output logic                               last
);

    // per-channel limits and position inside the block
    logic [mul_pkg::size_width-1:0] max_h [FLUX];
    logic [mul_pkg::size_width-1:0] max_v [FLUX];
    logic [mul_pkg::size_width-1:0] cnt_h [FLUX];
    logic [mul_pkg::size_width-1:0] cnt_v [FLUX];

    // context of the selected channel
    logic [mul_pkg::size_width-1:0] cur_h;
    logic [mul_pkg::size_width-1:0] cur_v;
    logic [mul_pkg::size_width-1:0] cur_max_h;
    logic [mul_pkg::size_width-1:0] cur_max_v;
    logic                           h_end;
    logic                           v_end;

    assign cur_h     = cnt_h[sel_tag];
    assign cur_v     = cnt_v[sel_tag];
    assign cur_max_h = max_h[sel_tag];
    assign cur_max_v = max_v[sel_tag];

    // end of a row, and end of the last row
    assign h_end = (cur_h == cur_max_h - 1'b1);
    assign v_end = (cur_v == cur_max_v - 1'b1);
    assign last  = h_end && v_end;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FLUX; i++)
            begin
                max_h[i] <= '0;
                max_v[i] <= '0;
                cnt_h[i] <= '0;
                cnt_v[i] <= '0;
            end
        end
        else if (load)
        begin
            // real size counts the inner loop, extent size the outer one
            max_h[sel_tag] <= real_data[sel_tag];
            max_v[sel_tag] <= ext_data[sel_tag];
            cnt_h[sel_tag] <= '0;
            cnt_v[sel_tag] <= '0;
        end
        else if (step)
        begin
            if (last)
            begin
                cnt_h[sel_tag] <= '0;
                cnt_v[sel_tag] <= '0;
            end
            else if (h_end)
            begin
                cnt_h[sel_tag] <= '0;
                cnt_v[sel_tag] <= cur_v + 1'b1;
            end
            else
            begin
                cnt_h[sel_tag] <= cur_h + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- flux_sched_fsm.sv
// FLUX must be at least 2; channel 0 has the highest priority and may starve the others
`default_nettype none

module flux_sched_fsm #(
    parameter int FLUX = 2
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [FLUX-1:0]          coeff_empty,
    input  wire logic [FLUX-1:0]          ext_empty,
    input  wire logic [FLUX-1:0]          real_empty,
    input  wire logic [FLUX-1:0]          opa_empty,
    input  wire logic [FLUX-1:0]          prod_full,
    input  wire logic                     last,
    output logic [$clog2(FLUX)-1:0]       sel_tag,
    output logic                          load,
    output logic                          step,
    output logic [FLUX-1:0]               coeff_read,
    output logic [FLUX-1:0]               ext_read,
    output logic [FLUX-1:0]               real_read,
    output logic [FLUX-1:0]               opa_read
);

    localparam int tag_width = $clog2(FLUX);

    mul_pkg::chan_state_t state [FLUX];

    // per-channel eligibility under the current flags
    logic [FLUX-1:0] ready;
    logic            grant;

    always_comb
    begin
        for (int i = 0; i < FLUX; i++)
        begin
            if (state[i] == mul_pkg::IDLE)
                ready[i] = !coeff_empty[i] && !ext_empty[i] && !real_empty[i];
            else
                ready[i] = !opa_empty[i] && !prod_full[i];
        end
    end

    // fixed priority, lowest channel number wins
    always_comb
    begin
        grant   = 1'b0;
        sel_tag = '0;
        for (int i = 0; i < FLUX; i++)
        begin
            if (ready[i] && !grant)
            begin
                grant   = 1'b1;
                sel_tag = tag_width'(i);
            end
        end
    end

    assign load = grant && (state[sel_tag] == mul_pkg::IDLE);
    assign step = grant && (state[sel_tag] == mul_pkg::WORK);

    // strobes go to the selected channel only
    always_comb
    begin
        for (int i = 0; i < FLUX; i++)
        begin
            coeff_read[i] = load && (sel_tag == tag_width'(i));
            ext_read[i]   = load && (sel_tag == tag_width'(i));
            real_read[i]  = load && (sel_tag == tag_width'(i));
            opa_read[i]   = step && (sel_tag == tag_width'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < FLUX; i++)
            begin
                state[i] <= mul_pkg::IDLE;
            end
        end
        else if (load)
        begin
            state[sel_tag] <= mul_pkg::WORK;
        end
        else if (step && last)
        begin
            // block done, wait for the next config set
            state[sel_tag] <= mul_pkg::IDLE;
        end
    end

endmodule

`default_nettype wire

//--- mul_pkg.sv
// widths are fixed for 18-bit operands and 9-bit coefficients; sizes must be 1 to 127
`default_nettype none

package mul_pkg;

    // signed operand from the opa FIFOs
    localparam int op_a_width = 18;

    // signed coefficient, one per block
    localparam int coeff_width = 9;

    // full-precision signed product, op_a_width + coeff_width
    localparam int prod_width = 27;

    // extent size and real size, zero is not a legal size
    localparam int size_width = 7;

    // per-channel scheduler state
    // IDLE waits for a full config set, WORK consumes operands
    typedef enum logic
    {
        IDLE = 1'b0,
        WORK = 1'b1
    } chan_state_t;

endpackage

`default_nettype wire
